// File: tim_bus_pkg.sv
package tim_bus_pkg;

  // ==============================
  // basic types
  // ==============================

  typedef logic [31:0] addr_t;  // byte address.
  typedef logic [31:0] word_t;
  typedef logic [3:0] strb_t;  // one enable bit per byte lane.

  // ==============================
  // processor side
  // ==============================

  // a nonzero wstrb marks a store, zero marks a load.
  typedef struct packed {
    logic valid;
    logic fence;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
  } cpu_req_t;

  typedef struct packed {
    logic ready;
    word_t rdata;
  } cpu_rsp_t;

  // ==============================
  // memory side
  // ==============================

  typedef struct packed {
    logic valid;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;  // zero for a read.
  } mem_req_t;

  // rdata is valid in the cycle that ready pulses.
  typedef struct packed {
    logic ready;
    word_t rdata;
  } mem_rsp_t;

endpackage

// File: tim_ctrl_pkg.sv
package tim_ctrl_pkg;

  // controller states.
  typedef enum logic [1:0] {
    lookup,
    fill,
    bypass,
    flush
  } tim_state_t;

  // result of classifying a captured request in the lookup state.
  typedef enum logic [2:0] {
    none,
    hit,
    miss,
    pass,
    fence
  } access_t;

endpackage

// File: tim_req_capture.sv
module tim_req_capture #(
  parameter int index_bits = 6,
  parameter tim_bus_pkg::addr_t base_addr = 32'h0000_1000,
  parameter tim_bus_pkg::addr_t top_addr = 32'h0000_2000,
  localparam int tag_bits = 30 - index_bits
) (
  input logic clock,
  input logic reset,
  input tim_bus_pkg::cpu_req_t req,
  input logic busy,
  output logic cap_valid,
  output logic cap_fence,
  output logic cap_store,
  output logic cap_in_window,
  output logic [tag_bits-1:0] cap_tag,
  output logic [index_bits-1:0] cap_index,
  output tim_bus_pkg::word_t cap_wdata,
  output tim_bus_pkg::strb_t cap_wstrb,
  output logic [index_bits-1:0] rd_index
);

  logic accept;

  assign accept = req.valid & ~busy;

  // the RAM registers this index, so the entry is readable with cap_valid.
  assign rd_index = req.addr[index_bits+1:2];

  always_ff @(posedge clock) begin
    if (!reset) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= accept;  // one cycle pulse per request.
    end
  end

  // the captured fields stay put until the next request is accepted.
  always_ff @(posedge clock) begin
    if (accept) begin
      cap_fence <= req.fence;
      cap_store <= |req.wstrb;
      cap_in_window <= (req.addr >= base_addr) && (req.addr < top_addr);
      cap_tag <= req.addr[31:index_bits+2];
      cap_index <= req.addr[index_bits+1:2];
      cap_wdata <= req.wdata;
      cap_wstrb <= req.wstrb;
    end
  end

  // the processor keeps one request outstanding, so none arrives while the
  // controller is still working on the previous one.
  a_no_req_while_busy : assert property (
    @(posedge clock) disable iff (!reset)
    req.valid |-> !busy
  );

endmodule

// File: tim_entry_ram.sv
module tim_entry_ram #(
  parameter int index_bits = 6,
  localparam int entry_bits = 2 + (30 - index_bits) + 32
) (
  input logic clock,
  input logic [index_bits-1:0] rd_index,
  output logic [entry_bits-1:0] rd_entry,
  input logic wr_en,
  input logic [index_bits-1:0] wr_index,
  input logic [entry_bits-1:0] wr_entry
);

  localparam int entries = 1 << index_bits;

  // each word holds lock, dirty, tag and data from the top bit down.
  logic [entry_bits-1:0] ram [entries];
  logic [index_bits-1:0] rd_index_q;

  always_ff @(posedge clock) begin
    rd_index_q <= rd_index;
    if (wr_en) begin
      ram[wr_index] <= wr_entry;
    end
  end

  // a write is seen by the next read of the same index.
  assign rd_entry = ram[rd_index_q];

endmodule

// File: tim_controller.sv
module tim_controller #(
  parameter int index_bits = 6,
  localparam int tag_bits = 30 - index_bits,
  localparam int entry_bits = 2 + tag_bits + 32
) (
  input logic clock,
  input logic reset,
  input logic cap_valid,
  input logic cap_fence,
  input logic cap_store,
  input logic cap_in_window,
  input logic [tag_bits-1:0] cap_tag,
  input logic [index_bits-1:0] cap_index,
  input tim_bus_pkg::word_t cap_wdata,
  input tim_bus_pkg::strb_t cap_wstrb,
  output logic busy,
  input logic [entry_bits-1:0] rd_entry,
  output logic [index_bits-1:0] flush_index,
  output logic flush_rd,
  output logic wr_en,
  output logic [index_bits-1:0] wr_index,
  output logic [entry_bits-1:0] wr_entry,
  output logic mem_start,
  output tim_bus_pkg::addr_t mem_addr,
  output tim_bus_pkg::word_t mem_wdata,
  output tim_bus_pkg::strb_t mem_wstrb,
  input logic mem_done,
  input tim_bus_pkg::word_t mem_data,
  output logic respond,
  output tim_bus_pkg::word_t resp_data
);

  typedef struct packed {
    logic lock;
    logic dirty;
    logic [tag_bits-1:0] tag;
    tim_bus_pkg::word_t data;
  } entry_t;

  tim_ctrl_pkg::tim_state_t state, state_next;
  tim_ctrl_pkg::access_t access;
  entry_t cur;
  entry_t upd;
  logic [index_bits-1:0] walk_index, walk_index_next;
  logic walk_ready, walk_ready_next;  // read data for walk_index is valid.
  logic wb_wait, wb_wait_next;  // a write-back is out to memory.
  logic walk_last;

  // replace the strobed byte lanes of old_word with those of new_word.
  function automatic tim_bus_pkg::word_t merge_bytes(
    input tim_bus_pkg::word_t old_word,
    input tim_bus_pkg::word_t new_word,
    input tim_bus_pkg::strb_t strb
  );
    tim_bus_pkg::word_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign cur = rd_entry;
  assign wr_entry = upd;
  assign busy = (state != tim_ctrl_pkg::lookup);
  assign flush_rd = (state == tim_ctrl_pkg::flush);  // the walk owns the read index.
  assign flush_index = walk_index;
  assign walk_last = &walk_index;

  // ==============================
  // lookup classification
  // ==============================

  always_comb begin
    access = tim_ctrl_pkg::none;
    if (state == tim_ctrl_pkg::lookup && cap_valid) begin
      if (cap_fence) begin
        access = tim_ctrl_pkg::fence;
      end else if (!cap_in_window) begin
        access = tim_ctrl_pkg::pass;
      end else if (!cur.lock) begin
        access = tim_ctrl_pkg::miss;
      end else if (cur.tag != cap_tag) begin
        access = tim_ctrl_pkg::pass;  // entry held by another tag.
      end else begin
        access = tim_ctrl_pkg::hit;
      end
    end
  end

  // ==============================
  // next state and outputs
  // ==============================

  always_comb begin
    state_next = state;
    walk_index_next = walk_index;
    walk_ready_next = walk_ready;
    wb_wait_next = wb_wait;
    wr_en = 1'b0;
    wr_index = cap_index;
    upd = '0;
    mem_start = 1'b0;
    mem_addr = {cap_tag, cap_index, 2'b00};
    mem_wdata = '0;
    mem_wstrb = '0;
    respond = 1'b0;
    resp_data = '0;

    case (state)
      tim_ctrl_pkg::lookup: begin
        case (access)
          tim_ctrl_pkg::hit: begin
            upd.lock = 1'b1;
            upd.dirty = cur.dirty | cap_store;
            upd.tag = cap_tag;
            upd.data = merge_bytes(cur.data, cap_wdata, cap_wstrb);
            wr_en = cap_store;  // loads leave the entry alone.
            respond = 1'b1;
            resp_data = cur.data;
          end
          tim_ctrl_pkg::miss: begin
            mem_start = 1'b1;  // full word read, the store bytes wait for the fill.
            state_next = tim_ctrl_pkg::fill;
          end
          tim_ctrl_pkg::pass: begin
            mem_start = 1'b1;
            mem_wdata = cap_wdata;
            mem_wstrb = cap_wstrb;
            state_next = tim_ctrl_pkg::bypass;
          end
          tim_ctrl_pkg::fence: begin
            walk_index_next = '0;
            walk_ready_next = 1'b0;
            wb_wait_next = 1'b0;
            state_next = tim_ctrl_pkg::flush;
          end
          default: begin
          end
        endcase
      end

      tim_ctrl_pkg::fill: begin
        if (mem_done) begin
          upd.lock = 1'b1;
          upd.dirty = cap_store;
          upd.tag = cap_tag;
          upd.data = merge_bytes(mem_data, cap_wdata, cap_wstrb);
          wr_en = 1'b1;
          respond = 1'b1;
          resp_data = mem_data;
          state_next = tim_ctrl_pkg::lookup;
        end
      end

      tim_ctrl_pkg::bypass: begin
        if (mem_done) begin
          respond = 1'b1;
          resp_data = mem_data;
          state_next = tim_ctrl_pkg::lookup;
        end
      end

      tim_ctrl_pkg::flush: begin
        wr_index = walk_index;
        mem_addr = {cur.tag, walk_index, 2'b00};  // address the word was cached from.
        mem_wdata = cur.data;
        mem_wstrb = 4'hf;
        if (!walk_ready) begin
          walk_ready_next = 1'b1;  // read index registered this cycle.
        end else if (cur.lock && cur.dirty && !wb_wait) begin
          mem_start = 1'b1;
          wb_wait_next = 1'b1;
        end else if (!wb_wait || mem_done) begin
          wr_en = 1'b1;  // upd is all zero, so the entry is unlocked.
          wb_wait_next = 1'b0;
          walk_ready_next = 1'b0;
          walk_index_next = walk_index + 1'b1;
          if (walk_last) begin
            respond = 1'b1;
            state_next = tim_ctrl_pkg::lookup;
          end
        end
      end

      default: begin
        state_next = tim_ctrl_pkg::lookup;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= tim_ctrl_pkg::lookup;
      walk_index <= '0;
      walk_ready <= 1'b0;
      wb_wait <= 1'b0;
    end else begin
      state <= state_next;
      walk_index <= walk_index_next;
      walk_ready <= walk_ready_next;
      wb_wait <= wb_wait_next;
    end
  end

  // after a start, the next start waits until memory has answered.
  a_one_access : assert property (
    @(posedge clock) disable iff (!reset)
    mem_start |=> (!mem_start until mem_done)
  );

  a_no_write_in_bypass : assert property (
    @(posedge clock) disable iff (!reset)
    (state == tim_ctrl_pkg::bypass) |-> !wr_en
  );

endmodule

// File: tim_bus_port.sv
module tim_bus_port (
  input logic clock,
  input logic reset,
  input logic mem_start,
  input tim_bus_pkg::addr_t mem_addr,
  input tim_bus_pkg::word_t mem_wdata,
  input tim_bus_pkg::strb_t mem_wstrb,
  output logic mem_done,
  output tim_bus_pkg::word_t mem_data,
  input logic respond,
  input tim_bus_pkg::word_t resp_data,
  output tim_bus_pkg::mem_req_t mem_req,
  input tim_bus_pkg::mem_rsp_t mem_rsp,
  output tim_bus_pkg::cpu_rsp_t cpu_rsp
);

  logic req_valid;
  tim_bus_pkg::addr_t req_addr;
  tim_bus_pkg::word_t req_wdata;
  tim_bus_pkg::strb_t req_wstrb;
  logic pending;  // an access is out and memory has not answered yet.
  logic rsp_ready;
  tim_bus_pkg::word_t rsp_rdata;

  assign mem_done = mem_rsp.ready & pending;
  assign mem_data = mem_rsp.rdata;

  always_ff @(posedge clock) begin
    if (!reset) begin
      req_valid <= 1'b0;
      pending <= 1'b0;
      rsp_ready <= 1'b0;
    end else begin
      req_valid <= mem_start;  // one cycle pulse.
      rsp_ready <= respond;
      if (mem_start) begin
        pending <= 1'b1;
      end else if (mem_rsp.ready) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mem_start) begin
      req_addr <= mem_addr;
      req_wdata <= mem_wdata;
      req_wstrb <= mem_wstrb;
    end
    if (respond) begin
      rsp_rdata <= resp_data;
    end
  end

  assign mem_req = '{valid: req_valid, addr: req_addr, wdata: req_wdata, wstrb: req_wstrb};
  assign cpu_rsp = '{ready: rsp_ready, rdata: rsp_rdata};

  // memory only answers an access that was launched.
  a_rsp_while_pending : assert property (
    @(posedge clock) disable iff (!reset)
    mem_rsp.ready |-> pending
  );

endmodule

// File: tim_top.sv
module tim_top #(
  parameter int index_bits = 6,
  parameter tim_bus_pkg::addr_t base_addr = 32'h0000_1000,
  parameter tim_bus_pkg::addr_t top_addr = 32'h0000_2000
) (
  input logic clock,
  input logic reset,
  input tim_bus_pkg::cpu_req_t cpu_req,
  output tim_bus_pkg::cpu_rsp_t cpu_rsp,
  output tim_bus_pkg::mem_req_t mem_req,
  input tim_bus_pkg::mem_rsp_t mem_rsp
);

  localparam int tag_bits = 30 - index_bits;
  localparam int entry_bits = 2 + tag_bits + 32;

  // capture stage to controller.
  logic cap_valid;
  logic cap_fence;
  logic cap_store;
  logic cap_in_window;
  logic [tag_bits-1:0] cap_tag;
  logic [index_bits-1:0] cap_index;
  tim_bus_pkg::word_t cap_wdata;
  tim_bus_pkg::strb_t cap_wstrb;
  logic busy;

  // entry RAM.
  logic [index_bits-1:0] cap_rd_index;
  logic [index_bits-1:0] flush_index;
  logic flush_rd;
  logic [index_bits-1:0] ram_rd_index;
  logic [entry_bits-1:0] rd_entry;
  logic wr_en;
  logic [index_bits-1:0] wr_index;
  logic [entry_bits-1:0] wr_entry;

  // controller to bus port.
  logic mem_start;
  tim_bus_pkg::addr_t mem_addr;
  tim_bus_pkg::word_t mem_wdata;
  tim_bus_pkg::strb_t mem_wstrb;
  logic mem_done;
  tim_bus_pkg::word_t mem_data;
  logic respond;
  tim_bus_pkg::word_t resp_data;

  assign ram_rd_index = flush_rd ? flush_index : cap_rd_index;  // the walk reads during a fence.

  tim_req_capture #(
    .index_bits(index_bits),
    .base_addr(base_addr),
    .top_addr(top_addr)
  ) tim_req_capture_inst (
    .clock(clock),
    .reset(reset),
    .req(cpu_req),
    .busy(busy),
    .cap_valid(cap_valid),
    .cap_fence(cap_fence),
    .cap_store(cap_store),
    .cap_in_window(cap_in_window),
    .cap_tag(cap_tag),
    .cap_index(cap_index),
    .cap_wdata(cap_wdata),
    .cap_wstrb(cap_wstrb),
    .rd_index(cap_rd_index)
  );

  tim_entry_ram #(
    .index_bits(index_bits)
  ) tim_entry_ram_inst (
    .clock(clock),
    .rd_index(ram_rd_index),
    .rd_entry(rd_entry),
    .wr_en(wr_en),
    .wr_index(wr_index),
    .wr_entry(wr_entry)
  );

  tim_controller #(
    .index_bits(index_bits)
  ) tim_controller_inst (
    .clock(clock),
    .reset(reset),
    .cap_valid(cap_valid),
    .cap_fence(cap_fence),
    .cap_store(cap_store),
    .cap_in_window(cap_in_window),
    .cap_tag(cap_tag),
    .cap_index(cap_index),
    .cap_wdata(cap_wdata),
    .cap_wstrb(cap_wstrb),
    .busy(busy),
    .rd_entry(rd_entry),
    .flush_index(flush_index),
    .flush_rd(flush_rd),
    .wr_en(wr_en),
    .wr_index(wr_index),
    .wr_entry(wr_entry),
    .mem_start(mem_start),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_done(mem_done),
    .mem_data(mem_data),
    .respond(respond),
    .resp_data(resp_data)
  );

  tim_bus_port tim_bus_port_inst (
    .clock(clock),
    .reset(reset),
    .mem_start(mem_start),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_done(mem_done),
    .mem_data(mem_data),
    .respond(respond),
    .resp_data(resp_data),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp),
    .cpu_rsp(cpu_rsp)
  );

endmodule

// File: tb_tim_top.sv
module tb_tim_top;

  localparam int index_bits = 6;
  localparam int tag_bits = 30 - index_bits;
  localparam int entries = 1 << index_bits;
  localparam tim_bus_pkg::addr_t base_addr = 32'h0000_1000;
  localparam tim_bus_pkg::addr_t top_addr = 32'h0000_2000;
  localparam int mem_size = 4096;  // words in the memory model.
  localparam int num_ops = 18;

  typedef enum logic [1:0] {
    op_read,
    op_write,
    op_fence
  } op_kind_t;

  typedef struct packed {
    op_kind_t kind;
    tim_bus_pkg::addr_t addr;
    tim_bus_pkg::word_t wdata;
    tim_bus_pkg::strb_t wstrb;
    tim_bus_pkg::word_t rdata;  // expected response data.
  } op_t;

  // memory starts as {addr[15:0] ^ 16'ha5a5, addr[15:0]} for every word.
  localparam op_t ops [num_ops] = '{
    '{op_fence, 32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000},
    '{op_read,  32'h0000_1010, 32'h0000_0000, 4'h0, 32'hb5b5_1010},  // cold miss.
    '{op_read,  32'h0000_1010, 32'h0000_0000, 4'h0, 32'hb5b5_1010},
    '{op_write, 32'h0000_1010, 32'h1122_3344, 4'h3, 32'hb5b5_1010},
    '{op_read,  32'h0000_1010, 32'h0000_0000, 4'h0, 32'hb5b5_3344},
    '{op_write, 32'h0000_1024, 32'haabb_ccdd, 4'hc, 32'hb581_1024},  // write miss.
    '{op_read,  32'h0000_1024, 32'h0000_0000, 4'h0, 32'haabb_1024},
    '{op_read,  32'h0000_0040, 32'h0000_0000, 4'h0, 32'ha5e5_0040},
    '{op_write, 32'h0000_2008, 32'h0102_0304, 4'hf, 32'h85ad_2008},
    '{op_read,  32'h0000_2008, 32'h0000_0000, 4'h0, 32'h0102_0304},
    '{op_read,  32'h0000_1110, 32'h0000_0000, 4'h0, 32'hb4b5_1110},  // same index as 0x1010.
    '{op_write, 32'h0000_1110, 32'hdead_beef, 4'h1, 32'hb4b5_1110},
    '{op_read,  32'h0000_1010, 32'h0000_0000, 4'h0, 32'hb5b5_3344},
    '{op_fence, 32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000},
    '{op_read,  32'h0000_1010, 32'h0000_0000, 4'h0, 32'hb5b5_3344},
    '{op_read,  32'h0000_1110, 32'h0000_0000, 4'h0, 32'hb4b5_11ef},
    '{op_read,  32'h0000_1024, 32'h0000_0000, 4'h0, 32'haabb_1024},
    '{op_fence, 32'h0000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000}
  };

  logic clock = 1'b0;
  logic reset;
  tim_bus_pkg::cpu_req_t cpu_req;
  tim_bus_pkg::cpu_rsp_t cpu_rsp;
  tim_bus_pkg::mem_req_t mem_req;
  tim_bus_pkg::mem_rsp_t mem_rsp;
  int cycle = 0;

  tim_bus_pkg::word_t mem_words [mem_size];
  tim_bus_pkg::mem_req_t log_req [$];  // requests seen by the memory model.
  int log_cycle [$];
  int rsp_cycle;
  tim_bus_pkg::mem_req_t exp_req [$];

  // reference copy of the entry state.
  logic ref_lock [entries];
  logic ref_dirty [entries];
  logic [tag_bits-1:0] ref_tag [entries];
  tim_bus_pkg::word_t ref_data [entries];

  tim_top #(
    .index_bits(index_bits),
    .base_addr(base_addr),
    .top_addr(top_addr)
  ) tim_top_inst (
    .clock(clock),
    .reset(reset),
    .cpu_req(cpu_req),
    .cpu_rsp(cpu_rsp),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp)
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;  // every reader at an edge sees the same count.
  end

  // ==============================
  // checks
  // ==============================

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s = %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input tim_bus_pkg::word_t got,
                            input tim_bus_pkg::word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s = %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input tim_bus_pkg::addr_t got,
                            input tim_bus_pkg::addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s = %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_strb(input string name, input tim_bus_pkg::strb_t got,
                            input tim_bus_pkg::strb_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s = %h, expected %h", name, got, exp));
    end
  endtask

  // write data only matters when some byte is written.
  task automatic check_mem_write(input tim_bus_pkg::mem_req_t got,
                                 input tim_bus_pkg::mem_req_t exp);
    check_addr("mem_req.addr", got.addr, exp.addr);
    check_strb("mem_req.wstrb", got.wstrb, exp.wstrb);
    if (exp.wstrb != '0) begin
      check_word("mem_req.wdata", got.wdata, exp.wdata);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("saw %0d %s where %0d were expected", got, what, exp));
    end
  endtask

  task automatic check_cycles(input string what, input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("%s came after %0d cycles instead of %0d", what, got, exp));
    end
  endtask

  task automatic check_idle();
    check_bit("cpu_rsp.ready", cpu_rsp.ready, 1'b0);
    check_bit("mem_req.valid", mem_req.valid, 1'b0);
  endtask

  // ==============================
  // models
  // ==============================

  function automatic tim_bus_pkg::word_t apply_strobe(input tim_bus_pkg::word_t old_word,
                                                      input tim_bus_pkg::word_t new_word,
                                                      input tim_bus_pkg::strb_t strb);
    tim_bus_pkg::word_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // fills exp_req with the memory traffic the operation should cause.
  task automatic predict(input op_t op, output tim_ctrl_pkg::access_t cls);
    logic [index_bits-1:0] idx;
    logic [index_bits-1:0] wb_index;
    logic [tag_bits-1:0] tag;
    tim_bus_pkg::addr_t line;
    logic store;
    idx = op.addr[index_bits+1:2];
    tag = op.addr[31:index_bits+2];
    line = {op.addr[31:2], 2'b00};
    store = |op.wstrb;
    exp_req.delete();
    if (op.kind == op_fence) begin
      cls = tim_ctrl_pkg::fence;
      for (int i = 0; i < entries; i++) begin
        wb_index = index_bits'(i);
        if (ref_lock[i] && ref_dirty[i]) begin
          exp_req.push_back('{valid: 1'b1, addr: {ref_tag[i], wb_index, 2'b00},
                              wdata: ref_data[i], wstrb: 4'hf});
        end
        ref_lock[i] = 1'b0;
        ref_dirty[i] = 1'b0;
      end
    end else if (op.addr < base_addr || op.addr >= top_addr ||
                 (ref_lock[idx] && ref_tag[idx] != tag)) begin
      cls = tim_ctrl_pkg::pass;
      exp_req.push_back('{valid: 1'b1, addr: line, wdata: op.wdata, wstrb: op.wstrb});
    end else if (!ref_lock[idx]) begin
      cls = tim_ctrl_pkg::miss;
      exp_req.push_back('{valid: 1'b1, addr: line, wdata: '0, wstrb: '0});
      ref_lock[idx] = 1'b1;
      ref_dirty[idx] = store;
      ref_tag[idx] = tag;
      ref_data[idx] = apply_strobe(mem_words[line[13:2]], op.wdata, op.wstrb);
    end else begin
      cls = tim_ctrl_pkg::hit;
      ref_dirty[idx] = ref_dirty[idx] | store;
      ref_data[idx] = apply_strobe(ref_data[idx], op.wdata, op.wstrb);
    end
  endtask

  initial begin : memory_model
    tim_bus_pkg::addr_t a;
    tim_bus_pkg::word_t held;
    int countdown;
    void'($urandom(32'hfff));
    countdown = 0;
    held = '0;
    rsp_cycle = 0;
    mem_rsp = '0;
    for (int i = 0; i < mem_size; i++) begin
      a = i << 2;
      mem_words[i] = {a[15:0] ^ 16'ha5a5, a[15:0]};
    end
    forever begin
      @(posedge clock);
      mem_rsp.ready <= 1'b0;
      if (countdown > 0) begin
        countdown = countdown - 1;
        if (countdown == 0) begin
          mem_rsp <= '{ready: 1'b1, rdata: held};
          rsp_cycle = cycle + 1;  // the DUT samples ready at the next edge.
        end
      end
      if (reset === 1'b1 && mem_req.valid === 1'b1) begin
        if (countdown > 0) begin
          fail_run("memory request arrived while the previous one was still open");
        end
        if (mem_req.addr >= 32'(mem_size * 4)) begin
          fail_run($sformatf("memory request to %h is outside the memory model", mem_req.addr));
        end
        log_req.push_back(mem_req);
        log_cycle.push_back(cycle);
        held = mem_words[mem_req.addr[13:2]];  // reads return the word before the write.
        mem_words[mem_req.addr[13:2]] = apply_strobe(held, mem_req.wdata, mem_req.wstrb);
        countdown = 1 + ($urandom % 4);
      end
    end
  end

  // ==============================
  // stimulus
  // ==============================

  task automatic run_op(input op_t op);
    tim_ctrl_pkg::access_t cls;
    int req_cycle;
    predict(op, cls);
    @(posedge clock);
    cpu_req <= '{valid: 1'b1, fence: op.kind == op_fence, addr: op.addr,
                 wdata: op.wdata, wstrb: op.wstrb};
    @(posedge clock);
    cpu_req.valid <= 1'b0;
    req_cycle = cycle;
    do begin
      @(posedge clock);
    end while (cpu_rsp.ready !== 1'b1);
    check_word("cpu_rsp.rdata", cpu_rsp.rdata, op.rdata);
    check_count("memory requests", log_req.size(), exp_req.size());
    foreach (exp_req[i]) begin
      check_mem_write(log_req[i], exp_req[i]);
    end
    if (cls == tim_ctrl_pkg::hit) begin
      check_cycles("hit response", cycle - req_cycle, 2);
    end else if (cls != tim_ctrl_pkg::fence) begin
      check_cycles("memory request", log_cycle[0] - req_cycle, 2);
      check_cycles("response after memory ready", cycle - rsp_cycle, 1);
    end
    log_req.delete();
    log_cycle.delete();
  endtask

  initial begin : watchdog
    int limit;
    limit = 20;
    for (int n = 0; n < num_ops; n++) begin
      limit = limit + 20;
      if (ops[n].kind == op_fence) begin
        limit = limit + 4 * entries;  // the walk visits every entry.
      end
    end
    repeat (limit) @(posedge clock);
    fail_run($sformatf("timeout after %0d cycles, the DUT stopped answering", limit));
  end

  initial begin : stimulus
    cpu_req = '0;
    reset = 1'b0;
    for (int i = 0; i < entries; i++) begin
      ref_lock[i] = 1'b0;  // entries start unlocked after reset.
      ref_dirty[i] = 1'b0;
      ref_tag[i] = '0;
      ref_data[i] = '0;
    end
    @(posedge clock);
    repeat (3) begin
      @(posedge clock);
      check_idle();
    end
    reset <= 1'b1;
    repeat (3) begin
      @(posedge clock);
      check_idle();
    end
    for (int n = 0; n < num_ops; n++) begin
      run_op(ops[n]);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: flist.f
tim_bus_pkg.sv
tim_ctrl_pkg.sv
tim_req_capture.sv
tim_entry_ram.sv
tim_controller.sv
tim_bus_port.sv
tim_top.sv
tb_tim_top.sv
